/* Makefile */
# Verilator build and run of the CPU memory bus testbench

VERILATOR ?= verilator
TOP ?= tb_cpu_mem_bus
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
+incdir+source
source/m92_pkg.sv
source/bank_latch.sv
source/address_translator.sv
source/cpu_bus_sequencer.sv
source/cpu_mem_bus.sv
testbench/sdram_model.sv
testbench/tb_cpu_mem_bus.sv

/* source/address_translator.sv */
// CPU memory map decoder
// maps a CPU address to an SDRAM address or a peripheral select,
// with ROM banking and the alternate video RAM mapping

module address_translator (
	input m92_pkg::cpu_addr_t addr,
	input m92_pkg::bank_t bank_select,
	input m92_pkg::board_cfg_t board_cfg,

	output m92_pkg::decode_t dec
);

	// bank bits merged over address bits 19..16 under the board mask
	m92_pkg::bank_t bank_a19_16;
	// page bits used for plain ROM accesses
	m92_pkg::bank_t rom_page;

	assign bank_a19_16 = (bank_select & board_cfg.bank_mask)
		| (addr[19:16] & ~board_cfg.bank_mask);

	// banked window is 0xa0000 to 0xbffff only
	assign rom_page = (addr[19:17] == 3'b101) ? bank_a19_16 : addr[19:16];

	// ==============================
	// memory map
	// ==============================

	always_comb begin
		// nothing selected unless a region matches
		dec = '0;

		casez (addr)
			// ROM at 0xc0000 to 0xcffff, read only
			20'b1100_????_????_????_????: begin
				dec.ram_rom = 1'b1;
				dec.sdr_addr = {m92_pkg::REGION_CPU_ROM_BASE[24:16], addr[15:0]};
			end
			// video RAM at 0xd0000 to 0xdffff
			20'b1101_????_????_????_????: begin
				dec.ram_rom = 1'b1;
				dec.writable = 1'b1;
				dec.sdr_addr = {m92_pkg::REGION_VRAM_BASE[24:16], addr[15:0]};
			end
			// work RAM at 0xe0000 to 0xeffff
			20'b1110_????_????_????_????: begin
				dec.ram_rom = 1'b1;
				dec.writable = 1'b1;
				dec.sdr_addr = {m92_pkg::REGION_CPU_RAM_BASE[24:16], addr[15:0]};
			end
			// eeprom, 0xf0000 to 0xf3fff
			20'b1111_00??_????_????_????: dec.eeprom = 1'b1;
			// sprite buffer from 0xf8000
			20'b1111_1000_????_????_????: dec.buffer = 1'b1;
			// sprite control registers 0xf9000 to 0xf900f
			20'b1111_1001_0000_0000_????: dec.sprite_control = 1'b1;
			// video control, two words at 0xf9800
			20'b1111_1001_1000_0000_000?: dec.video_control = 1'b1;
			// reset vector fetched from the ROM page ending 0x7fff
			20'b1111_1111_1111_1111_????: begin
				dec.ram_rom = 1'b1;
				dec.sdr_addr = {m92_pkg::REGION_CPU_ROM_BASE[24:20], 16'h7fff, addr[3:0]};
			end
			// rest of the 0xf0000 page has no device
			20'b1111_????_????_????_????: dec = '0;
			// 0x00000 to 0xbffff
			default: begin
				dec.ram_rom = 1'b1;
				if (board_cfg.alt_map && addr[19:16] == 4'h8) begin
					// some boards put video RAM in the 0x8xxxx page
					dec.writable = 1'b1;
					dec.sdr_addr = {m92_pkg::REGION_VRAM_BASE[24:16], addr[15:0]};
				end else begin
					dec.sdr_addr = {m92_pkg::REGION_CPU_ROM_BASE[24:20], rom_page, addr[15:0]};
				end
			end
		endcase
	end

endmodule

/* source/bank_latch.sv */
// ROM bank register
// loaded by CPU I/O writes to the bank port

`include "m92_defs.svh"

module bank_latch (
	input logic clk_sys,
	input logic rst,

	// CPU I/O write strobe and its port and data
	input logic io_wr,
	input logic [`M92_IO_AW-1:0] io_addr,
	input m92_pkg::bus_data_t io_wdata,

	// selects the 64 KB ROM page seen at 0xa0000 to 0xbffff
	output m92_pkg::bank_t bank
);

	logic bank_wr;

	// only the bank port loads the register
	assign bank_wr = io_wr && (io_addr == `M92_BANK_PORT);

	// ==============================
	// bank register
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			bank <= '0;
		end else if (bank_wr) begin
			// low data bits carry the bank number
			bank <= io_wdata[`M92_BANK_W-1:0];
		end
	end

endmodule

/* source/cpu_bus_sequencer.sv */
// CPU bus sequencer
// runs one CPU access at a time against SDRAM or a peripheral,
// drops ROM writes and answers with ready and read data

module cpu_bus_sequencer (
	input logic clk_sys,
	input logic rst,

	// CPU request and its decode, both valid on the strobe cycle
	input m92_pkg::cpu_req_t req,
	input m92_pkg::decode_t dec,

	// SDRAM request, held until ack
	output logic sdr_req,
	output m92_pkg::sdr_addr_t sdr_addr,
	output logic sdr_we,
	output m92_pkg::bus_data_t sdr_wdata,
	input logic sdr_ack,
	input m92_pkg::bus_data_t sdr_rdata,

	// peripheral pulses and CPU answer
	output m92_pkg::periph_sel_t periph_sel,
	output logic ready,
	output m92_pkg::bus_data_t rdata
);

	m92_pkg::seq_state_t state;

	// access being served
	m92_pkg::cpu_req_t req_q;
	m92_pkg::decode_t dec_q;

	logic strobe;
	logic to_sdram;
	logic responding;
	logic periph_hit;

	assign strobe = req.rd | req.wr;

	// reads of any ram/rom region, writes only where writable
	assign to_sdram = dec.ram_rom & (req.rd | dec.writable);

	// ==============================
	// state machine
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= m92_pkg::IDLE;
			sdr_req <= 1'b0;
		end else begin
			case (state)
				m92_pkg::IDLE: begin
					if (strobe && to_sdram) begin
						state <= m92_pkg::SDR_WAIT;
						sdr_req <= 1'b1;
					end else if (strobe) begin
						// peripheral, dropped write or unmapped
						state <= m92_pkg::RESPOND;
					end
				end
				m92_pkg::SDR_WAIT: begin
					// request stays up until the controller takes it
					if (sdr_ack) begin
						state <= m92_pkg::RESPOND;
						sdr_req <= 1'b0;
					end
				end
				m92_pkg::RESPOND: state <= m92_pkg::IDLE;
				default: state <= m92_pkg::IDLE;
			endcase
		end
	end

	// ==============================
	// request and data capture
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (state == m92_pkg::IDLE && strobe) begin
			req_q <= req;
			dec_q <= dec;
			// zero unless an SDRAM read fills it
			rdata <= '0;
		end
		// read data is only valid in the ack cycle
		if (state == m92_pkg::SDR_WAIT && sdr_ack && !req_q.wr) begin
			rdata <= sdr_rdata;
		end
	end

	// address and write data stay stable from the captured request
	assign sdr_addr = dec_q.sdr_addr;
	assign sdr_we = req_q.wr;
	assign sdr_wdata = req_q.wdata;

	// ready is the single RESPOND cycle
	assign responding = (state == m92_pkg::RESPOND);
	assign ready = responding;

	assign periph_hit = responding & (dec_q.buffer | dec_q.sprite_control
		| dec_q.video_control | dec_q.eeprom);

	// selects pulse together with ready, ram_rom accesses have none set
	always_comb begin
		periph_sel.buffer = responding & dec_q.buffer;
		periph_sel.sprite_control = responding & dec_q.sprite_control;
		periph_sel.video_control = responding & dec_q.video_control;
		periph_sel.eeprom = responding & dec_q.eeprom;
		periph_sel.we = periph_hit & req_q.wr;
		periph_sel.addr = periph_hit ? req_q.addr : '0;
	end

endmodule

/* source/cpu_mem_bus.sv */
// CPU side memory bus top level
// bank latch, address translator and bus sequencer

`include "m92_defs.svh"

module cpu_mem_bus (
	input logic clk_sys,
	input logic rst,
	input m92_pkg::board_cfg_t board_cfg,

	// CPU memory access
	input m92_pkg::cpu_req_t cpu_req,

	// CPU I/O writes
	input logic io_wr,
	input logic [`M92_IO_AW-1:0] io_addr,
	input m92_pkg::bus_data_t io_wdata,

	// SDRAM port
	output logic sdr_req,
	output m92_pkg::sdr_addr_t sdr_addr,
	output logic sdr_we,
	output m92_pkg::bus_data_t sdr_wdata,
	input logic sdr_ack,
	input m92_pkg::bus_data_t sdr_rdata,

	// peripherals and CPU answer
	output m92_pkg::periph_sel_t periph_sel,
	output logic ready,
	output m92_pkg::bus_data_t rdata
);

	m92_pkg::bank_t bank;
	m92_pkg::decode_t dec;

	// ==============================
	// submodules
	// ==============================

	bank_latch bank_latch (
		.clk_sys(clk_sys), .rst(rst),
		.io_wr(io_wr), .io_addr(io_addr), .io_wdata(io_wdata),
		.bank(bank)
	);

	// decode runs off the live CPU address
	address_translator address_translator (
		.addr(cpu_req.addr), .bank_select(bank),
		.board_cfg(board_cfg), .dec(dec)
	);

	cpu_bus_sequencer cpu_bus_sequencer (
		.clk_sys(clk_sys), .rst(rst),
		.req(cpu_req), .dec(dec),
		.sdr_req(sdr_req), .sdr_addr(sdr_addr), .sdr_we(sdr_we),
		.sdr_wdata(sdr_wdata), .sdr_ack(sdr_ack), .sdr_rdata(sdr_rdata),
		.periph_sel(periph_sel), .ready(ready), .rdata(rdata)
	);

endmodule

/* source/m92_defs.svh */
// bus width macros for the CPU memory decode
// bank register I/O port and SDRAM region base addresses

`ifndef M92_DEFS_SVH
`define M92_DEFS_SVH

// ==============================
// bus widths
// ==============================

// CPU memory address, 1 MB space
`define M92_CPU_AW 20
// SDRAM word address
`define M92_SDR_AW 25
// CPU and SDRAM data bus
`define M92_DW 16
// CPU I/O port address
`define M92_IO_AW 8
// ROM bank register width
`define M92_BANK_W 4

// I/O port that loads the ROM bank register
`define M92_BANK_PORT 8'h20

// ==============================
// SDRAM region bases
// ==============================

// only the upper bits take part in the address build
`define M92_ROM_BASE 25'h000_0000
`define M92_VRAM_BASE 25'h020_0000
`define M92_RAM_BASE 25'h021_0000

`endif

/* source/m92_pkg.sv */
// shared types for the CPU memory decode
// address typedefs, board configuration, region constants,
// bus structs and the sequencer state encoding

`include "m92_defs.svh"

package m92_pkg;

	// ==============================
	// plain vector types
	// ==============================

	typedef logic [`M92_CPU_AW-1:0] cpu_addr_t;
	typedef logic [`M92_SDR_AW-1:0] sdr_addr_t;
	typedef logic [`M92_DW-1:0] bus_data_t;
	typedef logic [`M92_BANK_W-1:0] bank_t;

	// per-board settings, static during a run
	typedef struct packed {
		// which of address bits 19..16 come from the bank register
		bank_t bank_mask;
		// 0x80000 page becomes writable video RAM
		logic alt_map;
	} board_cfg_t;

	// sdram placement of each memory region
	localparam sdr_addr_t REGION_CPU_ROM_BASE = `M92_ROM_BASE;
	localparam sdr_addr_t REGION_VRAM_BASE = `M92_VRAM_BASE;
	localparam sdr_addr_t REGION_CPU_RAM_BASE = `M92_RAM_BASE;

	// ==============================
	// bus bundles
	// ==============================

	// one CPU memory access, rd and wr are single cycle strobes
	typedef struct packed {
		cpu_addr_t addr;
		bus_data_t wdata;
		logic rd;
		logic wr;
	} cpu_req_t;

	// translator result for the current CPU address
	typedef struct packed {
		sdr_addr_t sdr_addr;
		logic writable;
		logic ram_rom;
		logic buffer;
		logic sprite_control;
		logic video_control;
		logic eeprom;
	} decode_t;

	// peripheral select pulses, one cycle wide
	typedef struct packed {
		logic buffer;
		logic sprite_control;
		logic video_control;
		logic eeprom;
		logic we;
		cpu_addr_t addr;
	} periph_sel_t;

	// bus sequencer states
	typedef enum logic [1:0] {
		IDLE,
		SDR_WAIT,
		RESPOND
	} seq_state_t;

endpackage

/* testbench/sdram_model.sv */
// SDRAM responder for the CPU memory bus testbench
// random acknowledge delay, sparse backing store and a write log

module sdram_model (
	input logic clk,
	input logic rst,

	input logic sdr_req,
	input m92_pkg::sdr_addr_t sdr_addr,
	input logic sdr_we,
	input m92_pkg::bus_data_t sdr_wdata,
	// cycles to wait before ack, sampled when a request starts
	input logic [2:0] ack_delay,
	output logic sdr_ack,
	output m92_pkg::bus_data_t sdr_rdata,

	// request counter and write log
	output logic [31:0] req_count,
	output logic [31:0] wr_count,
	output m92_pkg::sdr_addr_t last_wr_addr,
	output m92_pkg::bus_data_t last_wr_data
);

	// only written words are stored, the rest come from the fill pattern
	m92_pkg::bus_data_t store [m92_pkg::sdr_addr_t];

	logic busy;
	logic [2:0] wait_cnt;

	// fill pattern mixes every address bit
	function automatic m92_pkg::bus_data_t fill_word(input m92_pkg::sdr_addr_t a);
		return a[15:0] ^ {a[24:16], a[22:16]};
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			sdr_ack <= 1'b0;
			sdr_rdata <= '0;
			busy <= 1'b0;
			wait_cnt <= '0;
			req_count <= '0;
			wr_count <= '0;
			last_wr_addr <= '0;
			last_wr_data <= '0;
		end else begin
			sdr_ack <= 1'b0;
			if (busy) begin
				if (wait_cnt == 3'd0) begin
					busy <= 1'b0;
					sdr_ack <= 1'b1;
					if (sdr_we) begin
						store[sdr_addr] = sdr_wdata;
						wr_count <= wr_count + 32'd1;
						last_wr_addr <= sdr_addr;
						last_wr_data <= sdr_wdata;
						sdr_rdata <= '0;
					end else if (store.exists(sdr_addr)) begin
						sdr_rdata <= store[sdr_addr];
					end else begin
						sdr_rdata <= fill_word(sdr_addr);
					end
				end else begin
					wait_cnt <= wait_cnt - 3'd1;
				end
			end else if (sdr_req && !sdr_ack) begin
				// new request, the one just acked is still dropping
				busy <= 1'b1;
				wait_cnt <= ack_delay;
				req_count <= req_count + 32'd1;
			end
		end
	end

endmodule

/* testbench/tb_cpu_mem_bus.sv */
// testbench for the CPU memory bus top level
// LFSR stimulus, reference memory map, SDRAM model and watchdog

`include "m92_defs.svh"

module tb_cpu_mem_bus;

	localparam int N_TRANS = 400;

	logic clk;
	logic rst;
	m92_pkg::board_cfg_t board_cfg;
	m92_pkg::cpu_req_t cpu_req;
	logic io_wr;
	logic [`M92_IO_AW-1:0] io_addr;
	m92_pkg::bus_data_t io_wdata;
	logic sdr_req;
	m92_pkg::sdr_addr_t sdr_addr;
	logic sdr_we;
	m92_pkg::bus_data_t sdr_wdata;
	logic sdr_ack;
	m92_pkg::bus_data_t sdr_rdata;
	m92_pkg::periph_sel_t periph_sel;
	logic ready;
	m92_pkg::bus_data_t rdata;
	logic [2:0] ack_delay;
	logic [31:0] req_count;
	logic [31:0] wr_count;
	m92_pkg::sdr_addr_t last_wr_addr;
	m92_pkg::bus_data_t last_wr_data;

	// reference state
	logic [15:0] lfsr;
	m92_pkg::bank_t ref_bank;
	m92_pkg::bus_data_t ref_mem [m92_pkg::sdr_addr_t];

	cpu_mem_bus UUT (
		.clk_sys(clk), .rst(rst), .board_cfg(board_cfg), .cpu_req(cpu_req),
		.io_wr(io_wr), .io_addr(io_addr), .io_wdata(io_wdata),
		.sdr_req(sdr_req), .sdr_addr(sdr_addr), .sdr_we(sdr_we),
		.sdr_wdata(sdr_wdata), .sdr_ack(sdr_ack), .sdr_rdata(sdr_rdata),
		.periph_sel(periph_sel), .ready(ready), .rdata(rdata)
	);

	sdram_model sdram (
		.clk(clk), .rst(rst), .sdr_req(sdr_req), .sdr_addr(sdr_addr),
		.sdr_we(sdr_we), .sdr_wdata(sdr_wdata), .ack_delay(ack_delay),
		.sdr_ack(sdr_ack), .sdr_rdata(sdr_rdata), .req_count(req_count),
		.wr_count(wr_count), .last_wr_addr(last_wr_addr), .last_wr_data(last_wr_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ==============================
	// helpers
	// ==============================

	// fibonacci LFSR with taps 16 14 13 11
	// stepped once for every bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_stall(input string what);
		$display("no ready from the DUT while %s at %0t", what, $time);
		$display("Simulation failed");
		$fatal(1, "stalled access");
	endtask

	// untouched words read back as the model's fill pattern
	function automatic m92_pkg::bus_data_t expected_word(input m92_pkg::sdr_addr_t a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return a[15:0] ^ {a[24:16], a[22:16]};
	endfunction

	// memory map as the board defines it
	function automatic m92_pkg::decode_t ref_decode(input m92_pkg::cpu_addr_t a,
		input m92_pkg::bank_t bank, input m92_pkg::board_cfg_t cfg);
		m92_pkg::decode_t d;
		logic [3:0] page;
		d = '0;
		if (a >= 20'hc0000 && a < 20'hd0000) begin
			d.ram_rom = 1'b1;
			d.sdr_addr = `M92_ROM_BASE + {9'd0, a[15:0]};
		end else if (a >= 20'hd0000 && a < 20'he0000) begin
			d.ram_rom = 1'b1;
			d.writable = 1'b1;
			d.sdr_addr = `M92_VRAM_BASE + {9'd0, a[15:0]};
		end else if (a >= 20'he0000 && a < 20'hf0000) begin
			d.ram_rom = 1'b1;
			d.writable = 1'b1;
			d.sdr_addr = `M92_RAM_BASE + {9'd0, a[15:0]};
		end else if (a >= 20'hffff0) begin
			// reset vector page ends at 0x7fff
			d.ram_rom = 1'b1;
			d.sdr_addr = `M92_ROM_BASE + 25'h007fff0 + {21'd0, a[3:0]};
		end else if (a >= 20'hf0000) begin
			d.eeprom = (a < 20'hf4000);
			d.buffer = (a >= 20'hf8000 && a < 20'hf9000);
			d.sprite_control = (a >= 20'hf9000 && a <= 20'hf900f);
			d.video_control = (a == 20'hf9800 || a == 20'hf9801);
		end else if (cfg.alt_map && a[19:16] == 4'h8) begin
			d.ram_rom = 1'b1;
			d.writable = 1'b1;
			d.sdr_addr = `M92_VRAM_BASE + {9'd0, a[15:0]};
		end else begin
			d.ram_rom = 1'b1;
			page = a[19:16];
			if (a >= 20'ha0000)
				page = (bank & cfg.bank_mask) | (a[19:16] & ~cfg.bank_mask);
			d.sdr_addr = `M92_ROM_BASE + {5'd0, page, a[15:0]};
		end
		return d;
	endfunction

	// address from a random region class
	function automatic m92_pkg::cpu_addr_t gen_addr();
		logic [2:0] cls;
		logic [3:0] page;
		logic [1:0] sel;
		cls = 3'(rand_bits(3));
		case (cls)
			3'd0: begin
				page = 4'(rand_bits(4));
				if (page >= 4'd12)
					page = page - 4'd4;
				return {page, 16'(rand_bits(16))};
			end
			3'd1: return {3'b101, 17'(rand_bits(17))};
			3'd2: return {4'h8, 16'(rand_bits(16))};
			3'd3: begin
				sel = 2'(rand_bits(2));
				page = (sel == 2'd0) ? 4'hc : (sel == 2'd1) ? 4'hd : 4'he;
				return {page, 16'(rand_bits(16))};
			end
			3'd4: begin
				sel = 2'(rand_bits(2));
				case (sel)
					2'd0: return {6'b111100, 14'(rand_bits(14))};
					2'd1: return {8'hf8, 12'(rand_bits(12))};
					2'd2: return {16'hf900, 4'(rand_bits(4))};
					default: return 20'hf9800 | 20'(rand_bits(1));
				endcase
			end
			3'd5: return {16'hffff, 4'(rand_bits(4))};
			3'd6: return 20'hf4000 + 20'(rand_bits(14));
			default: return 20'(rand_bits(20));
		endcase
	endfunction

	// ==============================
	// bus tasks
	// ==============================

	task automatic io_write(input logic [`M92_IO_AW-1:0] port, input m92_pkg::bus_data_t data);
		@(negedge clk);
		io_wr = 1'b1;
		io_addr = port;
		io_wdata = data;
		@(negedge clk);
		io_wr = 1'b0;
		if (port == `M92_BANK_PORT)
			ref_bank = data[3:0];
	endtask

	// one CPU access that ends on a falling edge
	task automatic run_access(input m92_pkg::cpu_addr_t a, input m92_pkg::bus_data_t wd,
		input logic is_wr);
		m92_pkg::decode_t exp;
		m92_pkg::periph_sel_t exp_p;
		logic [31:0] req0;
		logic [31:0] wr0;
		logic sdram_path;
		int waited;
		exp = ref_decode(a, ref_bank, board_cfg);
		sdram_path = exp.ram_rom && (!is_wr || exp.writable);
		req0 = req_count;
		wr0 = wr_count;
		@(negedge clk);
		ack_delay = 3'(rand_bits(3));
		cpu_req.addr = a;
		cpu_req.wdata = wd;
		cpu_req.rd = !is_wr;
		cpu_req.wr = is_wr;
		@(negedge clk);
		cpu_req.rd = 1'b0;
		cpu_req.wr = 1'b0;
		if (sdram_path) begin
			check_value("sdr_we", 32'(sdr_we), 32'(is_wr));
			if (is_wr)
				check_value("sdr_wdata", 32'(sdr_wdata), 32'(wd));
			check_value("ready", 32'(ready), 32'd0);
			waited = 0;
			while (!ready) begin
				// request and its address stay up until the model acks
				check_value("sdr_req", 32'(sdr_req), 32'd1);
				check_value("sdr_addr", 32'(sdr_addr), 32'(exp.sdr_addr));
				check_value("periph_sel", 32'(periph_sel), 32'd0);
				@(negedge clk);
				waited++;
				if (waited > 40)
					report_stall("waiting on an SDRAM access");
			end
			// request is gone by the ready cycle
			check_value("sdr_req", 32'(sdr_req), 32'd0);
			check_value("periph_sel", 32'(periph_sel), 32'd0);
			check_value("rdata", 32'(rdata), is_wr ? 32'd0 : 32'(expected_word(exp.sdr_addr)));
			if (is_wr) begin
				check_value("wr_count", wr_count, wr0 + 32'd1);
				check_value("last_wr_addr", 32'(last_wr_addr), 32'(exp.sdr_addr));
				check_value("last_wr_data", 32'(last_wr_data), 32'(wd));
				ref_mem[exp.sdr_addr] = wd;
			end
		end else begin
			// peripheral, dropped ROM write or unmapped
			check_value("ready", 32'(ready), 32'd1);
			exp_p = '0;
			if (exp.buffer | exp.sprite_control | exp.video_control | exp.eeprom) begin
				exp_p.buffer = exp.buffer;
				exp_p.sprite_control = exp.sprite_control;
				exp_p.video_control = exp.video_control;
				exp_p.eeprom = exp.eeprom;
				exp_p.we = is_wr;
				exp_p.addr = a;
			end
			check_value("periph_sel", 32'(periph_sel), 32'(exp_p));
			check_value("rdata", 32'(rdata), 32'd0);
			check_value("sdr_req", 32'(sdr_req), 32'd0);
		end
		// ready and selects last a single cycle
		@(negedge clk);
		check_value("ready", 32'(ready), 32'd0);
		check_value("periph_sel", 32'(periph_sel), 32'd0);
		check_value("req_count", req_count, req0 + (sdram_path ? 32'd1 : 32'd0));
	endtask

	// ==============================
	// watchdog and main sequence
	// ==============================

	initial begin
		repeat (N_TRANS * 40) @(posedge clk);
		$display("run timed out before all accesses finished");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		m92_pkg::cpu_addr_t a;
		m92_pkg::bus_data_t wd;
		m92_pkg::decode_t d;
		logic is_wr;
		int t;
		rst = 1'b1;
		board_cfg = '0;
		cpu_req = '0;
		io_wr = 1'b0;
		io_addr = '0;
		io_wdata = '0;
		ack_delay = '0;
		lfsr = 16'd82;
		ref_bank = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value("ready", 32'(ready), 32'd0);
		check_value("sdr_req", 32'(sdr_req), 32'd0);
		check_value("periph_sel", 32'(periph_sel), 32'd0);

		for (t = 0; t < N_TRANS; t++) begin
			if (t % 16 == 0)
				board_cfg = m92_pkg::board_cfg_t'(5'(rand_bits(5)));
			// occasional I/O write with half of them to the bank port
			if (rand_bits(2) == 32'd0) begin
				if (rand_bits(1) == 32'd1)
					io_write(`M92_BANK_PORT, 16'(rand_bits(16)));
				else
					io_write(8'(rand_bits(8)), 16'(rand_bits(16)));
			end
			a = gen_addr();
			wd = 16'(rand_bits(16));
			is_wr = 1'(rand_bits(1));
			d = ref_decode(a, ref_bank, board_cfg);
			run_access(a, wd, is_wr);
			// read back RAM writes from the backing store
			if (is_wr && d.ram_rom && d.writable)
				run_access(a, 16'd0, 1'b0);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule
